/* decap.f */
rtl/decap_pkg.sv
rtl/decap_pio.sv
rtl/decap_mem_port.sv
rtl/decap_key_lookup.sv
rtl/decap_top.sv
testbench/decap_clk_gen.sv
testbench/decap_tb.sv

/* Bender.yml */
package:
  name: decap

sources:
  # Package first, then the design from the leaves up.
  - rtl/decap_pkg.sv
  - rtl/decap_pio.sv
  - rtl/decap_mem_port.sv
  - rtl/decap_key_lookup.sv
  - rtl/decap_top.sv

  - target: test
    files:
      - testbench/decap_clk_gen.sv
      - testbench/decap_tb.sv

/* testbench/decap_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decap_tb import decap_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000; // Several times the expected run length.
	localparam int N_KEYS         = 8;     // Programmed keys per engine.

	logic                 clk;
	logic                 arst_n, clk_div;
	logic                 reg_bs, reg_wr, reg_rd;
	logic [PIO_NBITS-1:0] reg_addr, reg_din;
	logic                 pio_ack, pio_rvalid;
	logic [PIO_NBITS-1:0] pio_rdata;
	logic                 rci_key_valid, ekey_key_valid;
	logic [KEY_NBITS-1:0] rci_key, ekey_key;
	logic                 rci_busy, rci_result_valid, rci_hit;
	logic                 ekey_busy, ekey_result_valid, ekey_hit;
	logic [PIO_NBITS-1:0] rci_value, ekey_value;

	logic [PIO_NBITS-1:0] shadow [4][MEM_DEPTH];   // Expected table contents.
	logic [KEY_NBITS-1:0] prog_keys [2][N_KEYS];
	logic [KEY_NBITS-1:0] rci_pending[$];          // Keys waiting for a result.
	logic [KEY_NBITS-1:0] ekey_pending[$];
	int                   error_count = 0;
	int                   cycle_count = 0;
	logic [1:0]           div_cnt;
	logic                 prev_div, prev_ack, prev_rvalid;

	decap_clk_gen clk_gen_i (.clk);

	decap_top decap_top_i (.*);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and compare.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic compare(input string name, input logic [PIO_NBITS-1:0] expected,
			input logic [PIO_NBITS-1:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("Error at %0t ns: %s expected 0x%h, actual 0x%h",
				$time, name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	function automatic logic [MEM_ADDR_NBITS-1:0] table_index(input logic [KEY_NBITS-1:0] k);
		return k[15:12] ^ k[11:8] ^ k[7:4] ^ k[3:0];
	endfunction

	// Hit flag on top of the value, engine 0 is RCI and 1 is EKEY.
	function automatic logic [PIO_NBITS:0] expected_lookup(input int eng,
			input logic [KEY_NBITS-1:0] k);
		hash_entry_u e;
		e.raw = shadow[2*eng][table_index(k)];
		if (e.f.valid && e.f.tag == k[KEY_NBITS-1 -: TAG_NBITS]) begin
			return {1'b1, shadow[2*eng+1][e.f.ptr]};
		end
		return '0;                       // Miss reports zero.
	endfunction

	task automatic check_result(input int eng, input logic hit, input logic [PIO_NBITS-1:0] value);
		logic [KEY_NBITS-1:0] k;
		logic [PIO_NBITS:0]   exp;
		string                prefix;
		prefix = (eng == 0) ? "rci" : "ekey";
		if ((eng == 0 ? rci_pending.size() : ekey_pending.size()) == 0) begin
			$display("Error at %0t ns: %s engine gave a result with no key outstanding",
				$time, prefix);
			$display("FAIL: see errors above");
			$fatal(1);
		end else begin
			if (eng == 0) begin
				k = rci_pending.pop_front();
			end else begin
				k = ekey_pending.pop_front();
			end
			exp = expected_lookup(eng, k);
			compare({prefix, "_hit"}, exp[PIO_NBITS], hit);
			compare({prefix, "_value"}, exp[PIO_NBITS-1:0], value);
		end
	endtask

	always @(negedge clk) begin
		if (arst_n && rci_result_valid) check_result(0, rci_hit, rci_value);
		if (arst_n && ekey_result_valid) check_result(1, ekey_hit, ekey_value);
	end

	// Acknowledges may move only after an edge that saw clk_div high.
	always @(negedge clk) begin
		if (arst_n && !prev_div) begin
			compare("pio_ack without strobe", prev_ack, pio_ack);
			compare("pio_rvalid without strobe", prev_rvalid, pio_rvalid);
		end
		prev_div    = clk_div;
		prev_ack    = pio_ack;
		prev_rvalid = pio_rvalid;
	end

	// Strobe every third cycle, and the run limit.
	always @(posedge clk) begin
		div_cnt     <= (div_cnt == 2'd2) ? 2'd0 : div_cnt + 2'd1;
		clk_div     <= (div_cnt == 2'd2);
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Error: run stopped after %0d cycles, an access never completed",
				TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host bus and lookup drivers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic pio_access(input logic wr, input logic [MEM_SEL_NBITS-1:0] sel,
			input logic [MEM_ADDR_NBITS-1:0] word, input logic [PIO_NBITS-1:0] data);
		logic [PIO_NBITS-1:0] expected;
		expected = (sel < 3'd4) ? shadow[sel[1:0]][word] : '0;
		@(posedge clk);
		reg_bs   <= 1'b1;
		reg_addr <= {21'd0, sel, 4'($urandom), word}; // Bits 7:4 are ignored.
		reg_din  <= data;
		reg_wr   <= wr;
		reg_rd   <= !wr;
		@(posedge clk);
		reg_wr <= 1'b0;
		reg_rd <= 1'b0;
		do @(negedge clk); while (!(wr ? pio_ack : pio_rvalid));
		if (!wr) begin
			compare("pio_rdata", expected, pio_rdata);
		end else if (sel < 3'd4) begin
			shadow[sel[1:0]][word] = data;
		end
		@(posedge clk);
		reg_bs <= 1'b0;
		do @(negedge clk); while (pio_ack || pio_rvalid);
		repeat ($urandom_range(2, 0)) @(posedge clk);
	endtask

	task automatic read_all_tables();
		for (int t = 0; t < 4; t++) begin
			for (int w = 0; w < MEM_DEPTH; w++) begin
				pio_access(1'b0, MEM_SEL_NBITS'(t), MEM_ADDR_NBITS'(w), '0);
			end
		end
	endtask

	task automatic random_reads(input int n);
		repeat (n) begin
			pio_access(1'b0, MEM_SEL_NBITS'($urandom_range(3, 0)),
				MEM_ADDR_NBITS'($urandom_range(MEM_DEPTH-1, 0)), '0);
		end
	endtask

	task automatic program_entry(input int eng, input logic [KEY_NBITS-1:0] k,
			input logic valid_bit, input logic [MEM_ADDR_NBITS-1:0] ptr);
		hash_entry_u e;
		e.raw     = $urandom;            // Reserved bits random.
		e.f.valid = valid_bit;
		e.f.tag   = k[KEY_NBITS-1 -: TAG_NBITS];
		e.f.ptr   = ptr;
		pio_access(1'b1, MEM_SEL_NBITS'(2 * eng), table_index(k), e.raw);
		pio_access(1'b1, MEM_SEL_NBITS'(2 * eng + 1), ptr, $urandom);
	endtask

	task automatic lookup(input int eng, input logic [KEY_NBITS-1:0] k);
		string prefix;
		prefix = (eng == 0) ? "rci" : "ekey";
		@(posedge clk);
		if (eng == 0) begin
			rci_pending.push_back(k);
			rci_key       <= k;
			rci_key_valid <= 1'b1;
		end else begin
			ekey_pending.push_back(k);
			ekey_key       <= k;
			ekey_key_valid <= 1'b1;
		end
		@(negedge clk);
		compare({prefix, "_busy"}, 1'b0, eng == 0 ? rci_busy : ekey_busy); // Idle when offered.
		@(posedge clk);
		if (eng == 0) rci_key_valid <= 1'b0;
		else ekey_key_valid <= 1'b0;
		@(negedge clk);
		compare({prefix, "_busy"}, 1'b1, eng == 0 ? rci_busy : ekey_busy);
		do @(negedge clk); while (!(eng == 0 ? rci_result_valid : ekey_result_valid));
		repeat ($urandom_range(3, 0)) @(posedge clk);
	endtask

	task automatic random_lookups(input int eng, input int n);
		logic [KEY_NBITS-1:0] k;
		repeat (n) begin
			k = $urandom;
			if ($urandom_range(1, 0)) k = prog_keys[eng][$urandom_range(N_KEYS-1, 0)];
			lookup(eng, k);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		void'($urandom(62761));
		arst_n         = 1'b0;
		clk_div        = 1'b0;
		div_cnt        = 2'd0;
		reg_bs         = 1'b0;
		reg_wr         = 1'b0;
		reg_rd         = 1'b0;
		reg_addr       = '0;
		reg_din        = '0;
		rci_key_valid  = 1'b0;
		rci_key        = '0;
		ekey_key_valid = 1'b0;
		ekey_key       = '0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// Fill every table, then read it back.
		for (int t = 0; t < 4; t++) begin
			for (int w = 0; w < MEM_DEPTH; w++) begin
				pio_access(1'b1, MEM_SEL_NBITS'(t), MEM_ADDR_NBITS'(w), $urandom);
			end
		end
		read_all_tables();

		// Unmapped codes complete, read zero and touch no table.
		for (int s = 4; s < 8; s++) begin
			pio_access(1'b1, MEM_SEL_NBITS'(s), 4'($urandom), $urandom);
			pio_access(1'b0, MEM_SEL_NBITS'(s), 4'($urandom), '0);
		end
		read_all_tables();

		// Every fourth entry is left invalid.
		for (int e = 0; e < 2; e++) begin
			for (int i = 0; i < N_KEYS; i++) begin
				prog_keys[e][i] = $urandom;
				program_entry(e, prog_keys[e][i], (i % 4) != 3, MEM_ADDR_NBITS'(i));
			end
		end
		// Flipping key bits 4 and 8 keeps the index and breaks the tag.
		for (int e = 0; e < 2; e++) begin
			for (int i = 0; i < N_KEYS; i++) begin
				lookup(e, prog_keys[e][i]);
				lookup(e, prog_keys[e][i] ^ 16'h0110);
			end
		end

		fork
			random_lookups(0, 40);
			random_lookups(1, 40);
			random_reads(60);
		join

		repeat (4) @(posedge clk);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/decap_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module decap_clk_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;   // 20 ns period.

endmodule

`default_nettype wire

/* rtl/decap_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decap_top import decap_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 clk_div,

	// Host register bus.
	input  logic                 reg_bs,
	input  logic                 reg_wr,
	input  logic                 reg_rd,
	input  logic [PIO_NBITS-1:0] reg_addr,
	input  logic [PIO_NBITS-1:0] reg_din,
	output logic                 pio_ack,
	output logic                 pio_rvalid,
	output logic [PIO_NBITS-1:0] pio_rdata,

	// RCI lookup.
	input  logic                 rci_key_valid,
	input  logic [KEY_NBITS-1:0] rci_key,
	output logic                 rci_busy,
	output logic                 rci_result_valid,
	output logic                 rci_hit,
	output logic [PIO_NBITS-1:0] rci_value,

	// EKEY lookup.
	input  logic                 ekey_key_valid,
	input  logic [KEY_NBITS-1:0] ekey_key,
	output logic                 ekey_busy,
	output logic                 ekey_result_valid,
	output logic                 ekey_hit,
	output logic [PIO_NBITS-1:0] ekey_value
);

	logic                      sel_rci_hash, sel_rci_value, sel_ekey_hash, sel_ekey_value;
	logic                      rci_hash_ack, rci_value_ack, ekey_hash_ack, ekey_value_ack;
	logic [PIO_NBITS-1:0]      rci_hash_rdata, rci_value_rdata;
	logic [PIO_NBITS-1:0]      ekey_hash_rdata, ekey_value_rdata;
	logic [MEM_ADDR_NBITS-1:0] mem_addr;

	// Engine to memory links.
	logic                      rci_hash_req, rci_value_req, ekey_hash_req, ekey_value_req;
	logic                      rci_hash_lk_ack, rci_value_lk_ack;
	logic                      ekey_hash_lk_ack, ekey_value_lk_ack;
	logic [MEM_ADDR_NBITS-1:0] rci_hash_addr, rci_value_addr;
	logic [MEM_ADDR_NBITS-1:0] ekey_hash_addr, ekey_value_addr;
	logic [PIO_NBITS-1:0]      rci_hash_lk_rdata, rci_value_lk_rdata;
	logic [PIO_NBITS-1:0]      ekey_hash_lk_rdata, ekey_value_lk_rdata;

	assign mem_addr = reg_addr[MEM_ADDR_NBITS-1:0];

	decap_pio decap_pio_i (
		.clk, .arst_n, .clk_div, .reg_bs, .reg_wr, .reg_rd, .reg_addr, .reg_din,
		.rci_hash_ack, .rci_value_ack, .ekey_hash_ack, .ekey_value_ack,
		.rci_hash_rdata, .rci_value_rdata, .ekey_hash_rdata, .ekey_value_rdata,
		.sel_rci_hash, .sel_rci_value, .sel_ekey_hash, .sel_ekey_value,
		.pio_ack, .pio_rvalid, .pio_rdata
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Table memories.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	decap_mem_port rci_hash_mem_i (
		.clk, .arst_n, .sel(sel_rci_hash), .reg_wr, .reg_rd,
		.pio_addr(mem_addr), .pio_wdata(reg_din),
		.mem_ack(rci_hash_ack), .mem_rdata(rci_hash_rdata),
		.lk_req(rci_hash_req), .lk_addr(rci_hash_addr),
		.lk_ack(rci_hash_lk_ack), .lk_rdata(rci_hash_lk_rdata)
	);

	decap_mem_port rci_value_mem_i (
		.clk, .arst_n, .sel(sel_rci_value), .reg_wr, .reg_rd,
		.pio_addr(mem_addr), .pio_wdata(reg_din),
		.mem_ack(rci_value_ack), .mem_rdata(rci_value_rdata),
		.lk_req(rci_value_req), .lk_addr(rci_value_addr),
		.lk_ack(rci_value_lk_ack), .lk_rdata(rci_value_lk_rdata)
	);

	decap_mem_port ekey_hash_mem_i (
		.clk, .arst_n, .sel(sel_ekey_hash), .reg_wr, .reg_rd,
		.pio_addr(mem_addr), .pio_wdata(reg_din),
		.mem_ack(ekey_hash_ack), .mem_rdata(ekey_hash_rdata),
		.lk_req(ekey_hash_req), .lk_addr(ekey_hash_addr),
		.lk_ack(ekey_hash_lk_ack), .lk_rdata(ekey_hash_lk_rdata)
	);

	decap_mem_port ekey_value_mem_i (
		.clk, .arst_n, .sel(sel_ekey_value), .reg_wr, .reg_rd,
		.pio_addr(mem_addr), .pio_wdata(reg_din),
		.mem_ack(ekey_value_ack), .mem_rdata(ekey_value_rdata),
		.lk_req(ekey_value_req), .lk_addr(ekey_value_addr),
		.lk_ack(ekey_value_lk_ack), .lk_rdata(ekey_value_lk_rdata)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup engines.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	decap_key_lookup rci_lookup_i (
		.clk, .arst_n, .key_valid(rci_key_valid), .key(rci_key),
		.busy(rci_busy), .result_valid(rci_result_valid), .hit(rci_hit), .value(rci_value),
		.hash_req(rci_hash_req), .hash_addr(rci_hash_addr),
		.hash_ack(rci_hash_lk_ack), .hash_rdata(rci_hash_lk_rdata),
		.value_req(rci_value_req), .value_addr(rci_value_addr),
		.value_ack(rci_value_lk_ack), .value_rdata(rci_value_lk_rdata)
	);

	decap_key_lookup ekey_lookup_i (
		.clk, .arst_n, .key_valid(ekey_key_valid), .key(ekey_key),
		.busy(ekey_busy), .result_valid(ekey_result_valid), .hit(ekey_hit),
		.value(ekey_value),
		.hash_req(ekey_hash_req), .hash_addr(ekey_hash_addr),
		.hash_ack(ekey_hash_lk_ack), .hash_rdata(ekey_hash_lk_rdata),
		.value_req(ekey_value_req), .value_addr(ekey_value_addr),
		.value_ack(ekey_value_lk_ack), .value_rdata(ekey_value_lk_rdata)
	);

endmodule

`default_nettype wire

/* rtl/decap_key_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module decap_key_lookup import decap_pkg::*; (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      key_valid,
	input  logic [KEY_NBITS-1:0]      key,
	output logic                      busy,
	output logic                      result_valid,
	output logic                      hit,
	output logic [PIO_NBITS-1:0]      value,

	// Hash table port.
	output logic                      hash_req,
	output logic [MEM_ADDR_NBITS-1:0] hash_addr,
	input  logic                      hash_ack,
	input  hash_entry_u               hash_rdata,

	// Value table port.
	output logic                      value_req,
	output logic [MEM_ADDR_NBITS-1:0] value_addr,
	input  logic                      value_ack,
	input  logic [PIO_NBITS-1:0]      value_rdata
);

	logic [LK_ST_NBITS-1:0]    state;
	logic [KEY_NBITS-1:0]      key_q;
	logic [MEM_ADDR_NBITS-1:0] ptr_q;
	logic                      tag_match;

	// XOR of all key nibbles.
	function automatic logic [MEM_ADDR_NBITS-1:0] key_hash(input logic [KEY_NBITS-1:0] k);
		logic [MEM_ADDR_NBITS-1:0] h;
		h = '0;
		for (int i = 0; i < KEY_NBITS / MEM_ADDR_NBITS; i++) begin
			h = h ^ k[i*MEM_ADDR_NBITS +: MEM_ADDR_NBITS];
		end
		return h;
	endfunction

	assign busy         = (state != LK_IDLE);
	assign result_valid = (state == LK_DONE);
	assign hash_req     = (state == LK_HASH);
	assign hash_addr    = key_hash(key_q);
	assign value_req    = (state == LK_VALUE);
	assign value_addr   = ptr_q;

	assign tag_match = hash_rdata.f.valid &&
		(hash_rdata.f.tag == key_q[KEY_NBITS-1 -: TAG_NBITS]);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup FSM.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= LK_IDLE;
			hit   <= 1'b0;
		end else begin
			case (state)
				LK_IDLE: begin
					if (key_valid) begin
						state <= LK_HASH;
					end
				end
				LK_HASH: begin
					if (hash_ack) begin
						hit   <= 1'b0;
						state <= tag_match ? LK_VALUE : LK_DONE; // Miss skips the value read.
					end
				end
				LK_VALUE: begin
					if (value_ack) begin
						hit   <= 1'b1;
						state <= LK_DONE;
					end
				end
				default: begin
					state <= LK_IDLE;  // Result shown for one cycle.
				end
			endcase
		end
	end

	// Key, pointer and result value.
	always_ff @(posedge clk) begin
		if (state == LK_IDLE && key_valid) begin
			key_q <= key;
		end
		if (state == LK_HASH && hash_ack) begin
			ptr_q <= hash_rdata.f.ptr;
			value <= '0;
		end
		if (state == LK_VALUE && value_ack) begin
			value <= value_rdata;
		end
	end

endmodule

`default_nettype wire

/* rtl/decap_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module decap_mem_port import decap_pkg::*; (
	input  logic                      clk,
	input  logic                      arst_n,

	// PIO side.
	input  logic                      sel,
	input  logic                      reg_wr,
	input  logic                      reg_rd,
	input  logic [MEM_ADDR_NBITS-1:0] pio_addr,
	input  logic [PIO_NBITS-1:0]      pio_wdata,
	output logic                      mem_ack,
	output logic [PIO_NBITS-1:0]      mem_rdata,

	// Lookup engine side.
	input  logic                      lk_req,
	input  logic [MEM_ADDR_NBITS-1:0] lk_addr,
	output logic                      lk_ack,
	output logic [PIO_NBITS-1:0]      lk_rdata
);

	logic [PIO_NBITS-1:0] mem [MEM_DEPTH];

	logic pio_pend;   // PIO access waiting for the memory.
	logic pio_wr;     // Latched access type.
	logic lk_gnt;
	logic pio_gnt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Arbiter. Lookup first, each grant served in its own cycle.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lk_gnt  = lk_req & ~lk_ack;    // Request still high in the ack cycle.
	assign pio_gnt = pio_pend & ~lk_gnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pio_pend <= 1'b0;
			pio_wr   <= 1'b0;
			lk_ack   <= 1'b0;
			mem_ack  <= 1'b0;
		end else begin
			// Access type comes from the single-cycle strobe.
			if (sel && (reg_wr || reg_rd)) begin
				pio_pend <= 1'b1;
				pio_wr   <= reg_wr;
			end else if (pio_gnt || !sel) begin
				pio_pend <= 1'b0; // Served once per select.
			end

			lk_ack <= lk_gnt;                 // One-cycle pulse.

			if (!sel) begin
				mem_ack <= 1'b0;
			end else if (pio_gnt) begin
				mem_ack <= 1'b1;              // Held until select falls.
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Table storage and read registers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (pio_gnt && pio_wr) begin
			mem[pio_addr] <= pio_wdata;      // Write lands in the grant cycle.
		end
		if (pio_gnt && !pio_wr) begin
			mem_rdata <= mem[pio_addr];
		end
		if (lk_gnt) begin
			lk_rdata <= mem[lk_addr];
		end
	end

endmodule

`default_nettype wire

/* rtl/decap_pio.sv */
`timescale 1ns/1ps
`default_nettype none

module decap_pio import decap_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 clk_div,

	input  logic                 reg_bs,
	input  logic                 reg_wr,
	input  logic                 reg_rd,
	input  logic [PIO_NBITS-1:0] reg_addr,
	input  logic [PIO_NBITS-1:0] reg_din,

	input  logic                 rci_hash_ack,
	input  logic                 rci_value_ack,
	input  logic                 ekey_hash_ack,
	input  logic                 ekey_value_ack,
	input  logic [PIO_NBITS-1:0] rci_hash_rdata,
	input  logic [PIO_NBITS-1:0] rci_value_rdata,
	input  logic [PIO_NBITS-1:0] ekey_hash_rdata,
	input  logic [PIO_NBITS-1:0] ekey_value_rdata,

	output logic                 sel_rci_hash,
	output logic                 sel_rci_value,
	output logic                 sel_ekey_hash,
	output logic                 sel_ekey_value,

	output logic                 pio_ack,
	output logic                 pio_rvalid,
	output logic [PIO_NBITS-1:0] pio_rdata
);

	logic [MEM_SEL_NBITS-1:0] mem_sel;
	logic                     n_ack;      // Served level of the addressed target.
	logic [PIO_NBITS-1:0]     n_rdata;
	logic                     acc_start;
	logic                     acc_pend;   // Access seen, not yet completed.
	logic                     acc_rd;     // Access type, latched at start.
	logic                     acc_done;
	logic                     rd_pend;

	assign mem_sel   = reg_addr[MEM_SEL_LSB +: MEM_SEL_NBITS];
	assign acc_start = reg_bs & (reg_wr | reg_rd);
	assign acc_done  = clk_div & acc_pend & n_ack; // Completes on a strobe only.
	assign rd_pend   = acc_pend & acc_rd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode and return mux.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		sel_rci_hash   = 1'b0;
		sel_rci_value  = 1'b0;
		sel_ekey_hash  = 1'b0;
		sel_ekey_value = 1'b0;
		n_ack          = 1'b1;        // Unmapped codes answer by themselves.
		n_rdata        = '0;          // And read as zero.
		case (mem_sel)
			SEL_RCI_HASH: begin
				sel_rci_hash = reg_bs;
				n_ack        = rci_hash_ack;
				n_rdata      = rci_hash_rdata;
			end
			SEL_RCI_VALUE: begin
				sel_rci_value = reg_bs;
				n_ack         = rci_value_ack;
				n_rdata       = rci_value_rdata;
			end
			SEL_EKEY_HASH: begin
				sel_ekey_hash = reg_bs;
				n_ack         = ekey_hash_ack;
				n_rdata       = ekey_hash_rdata;
			end
			SEL_EKEY_VALUE: begin
				sel_ekey_value = reg_bs;
				n_ack          = ekey_value_ack;
				n_rdata        = ekey_value_rdata;
			end
			default: begin
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Completion, registered on clk_div strobes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc_pend   <= 1'b0;
			acc_rd     <= 1'b0;
			pio_ack    <= 1'b0;
			pio_rvalid <= 1'b0;
		end else begin
			if (acc_start) begin
				acc_pend <= 1'b1;
				acc_rd   <= reg_rd;
			end else if (acc_done) begin
				acc_pend <= 1'b0;
			end
			if (clk_div) begin
				pio_ack    <= acc_done & ~acc_rd; // Held for one strobe period.
				pio_rvalid <= acc_done & rd_pend;
			end
		end
	end

	// Read data is captured with pio_rvalid and stays valid alongside it.
	always_ff @(posedge clk) begin
		if (acc_done && rd_pend) begin
			pio_rdata <= n_rdata;
		end
	end

endmodule

`default_nettype wire

/* rtl/decap_pkg.sv */
`default_nettype none

package decap_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host bus and table geometry.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int PIO_NBITS      = 32;
	localparam int MEM_SEL_LSB    = 8;   // Memory select field in reg_addr.
	localparam int MEM_SEL_NBITS  = 3;
	localparam int MEM_ADDR_NBITS = 4;   // Word index, reg_addr[3:0].
	localparam int MEM_DEPTH      = 16;

	// Select codes. Codes 4 to 7 hit no table.
	localparam logic [MEM_SEL_NBITS-1:0] SEL_RCI_HASH   = 3'd0;
	localparam logic [MEM_SEL_NBITS-1:0] SEL_RCI_VALUE  = 3'd1;
	localparam logic [MEM_SEL_NBITS-1:0] SEL_EKEY_HASH  = 3'd2;
	localparam logic [MEM_SEL_NBITS-1:0] SEL_EKEY_VALUE = 3'd3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Key lookup.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int KEY_NBITS = 16;
	localparam int TAG_NBITS = 12;       // Upper key bits kept in the entry.

	// Lookup FSM state codes.
	localparam int LK_ST_NBITS = 2;
	localparam logic [LK_ST_NBITS-1:0] LK_IDLE  = 2'd0;
	localparam logic [LK_ST_NBITS-1:0] LK_HASH  = 2'd1;
	localparam logic [LK_ST_NBITS-1:0] LK_VALUE = 2'd2;
	localparam logic [LK_ST_NBITS-1:0] LK_DONE  = 2'd3;

	// One hash table word. The host writes it raw, the engine reads the fields.
	typedef union packed {
		logic [PIO_NBITS-1:0] raw;
		struct packed {
			logic                      valid; // Bit 31.
			logic [TAG_NBITS-1:0]      tag;   // Bits 30:19.
			logic [MEM_ADDR_NBITS-1:0] ptr;   // Bits 18:15, value table index.
			logic [14:0]               rsvd;
		} f;
	} hash_entry_u;

endpackage

`default_nettype wire
